/* source/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Width of one operand, one bus value and one general register
`define ALU_WORD_WIDTH 32

// Number of general registers on the bus
// Register address width follows from this count
`define ALU_REG_COUNT 16

// ALU result is always two words wide
// High half for remainder or upper product bits

`endif

/* source/alu_pkg.sv */
`include "alu_config.svh"

package alu_pkg;

	// One bus value or operand
	typedef logic [`ALU_WORD_WIDTH-1:0] word_t;

	// Full ALU result, kept as two halves
	// Product upper bits or remainder go in hi
	typedef struct packed {
		word_t hi;
		word_t lo;
	} dword_t;

	// Operation codes, encoding shared with the control sequencer
	// Codes 13 to 15 are spare and give a zero result
	typedef enum logic [3:0] {
		OP_AND  = 4'd0,
		OP_OR   = 4'd1,
		OP_NEG  = 4'd2,
		OP_NOT  = 4'd3,
		OP_ADD  = 4'd4,
		OP_SUB  = 4'd5,
		OP_MUL  = 4'd6,
		OP_DIV  = 4'd7,
		OP_SHR  = 4'd8,
		OP_SHRA = 4'd9,
		OP_SHL  = 4'd10,
		OP_ROR  = 4'd11,
		OP_ROL  = 4'd12
	} alu_op_t;

endpackage

/* source/bus_pkg.sv */
`include "alu_config.svh"

package bus_pkg;

	// What drives the internal bus
	typedef enum logic [1:0] {
		// Register bank read port
		BUS_SRC_REG  = 2'd0,
		// External input port
		BUS_SRC_IN   = 2'd1,
		// Low and high halves of Z
		BUS_SRC_Z_LO = 2'd2,
		BUS_SRC_Z_HI = 2'd3
	} bus_src_t;

	// General register number
	typedef logic [$clog2(`ALU_REG_COUNT)-1:0] reg_addr_t;

endpackage

/* source/register_bank.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module register_bank (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               write_en,
	input  bus_pkg::reg_addr_t addr,
	input  alu_pkg::word_t     write_data,
	output alu_pkg::word_t     read_data
);

	// General register storage
	alu_pkg::word_t regs [`ALU_REG_COUNT];

	// Single write port, written from the bus
	// Reset clears every register so bus reads return zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `ALU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[addr] <= write_data;
		end
	end

	// Read is combinational, same address as the write
	// A write shows up on the read port after the edge
	assign read_data = regs[addr];

endmodule

/* source/booth_multiplier.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module booth_multiplier (
	input  alu_pkg::word_t  multiplicand,
	input  alu_pkg::word_t  multiplier,
	output alu_pkg::dword_t product
);

	localparam int W = `ALU_WORD_WIDTH;
	// One recoded digit per bit pair
	localparam int DIGITS = W / 2;

	// Multiplier with an implied zero below bit 0
	logic [W:0] mult_ext;
	// Multiplicand sign-extended to the product width, and doubled
	logic [2*W-1:0] mcand_x1;
	logic [2*W-1:0] mcand_x2;
	// Unshifted partial product per digit
	logic [2*W-1:0] digit_pp [DIGITS];
	logic [2*W-1:0] acc;

	assign mult_ext = {multiplier, 1'b0};
	assign mcand_x1 = {{W{multiplicand[W-1]}}, multiplicand};
	assign mcand_x2 = {mcand_x1[2*W-2:0], 1'b0};

	// Recode each overlapping triple into a digit from -2 to +2
	always_comb begin
		for (int i = 0; i < DIGITS; i++) begin
			case (mult_ext[2*i +: 3])
				3'b001, 3'b010: digit_pp[i] = mcand_x1;
				3'b011:         digit_pp[i] = mcand_x2;
				3'b100:         digit_pp[i] = -mcand_x2;
				3'b101, 3'b110: digit_pp[i] = -mcand_x1;
				// 000 and 111 both recode to zero
				default:        digit_pp[i] = '0;
			endcase
		end
	end

	// Weight each digit by 4^i and sum
	// Wrap at 64 bits gives the signed product directly
	always_comb begin
		acc = '0;
		for (int i = 0; i < DIGITS; i++) begin
			acc = acc + (digit_pp[i] << (2 * i));
		end
	end

	assign product = acc;

endmodule

/* source/nonrestoring_divider.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module nonrestoring_divider (
	input  alu_pkg::word_t  dividend,
	input  alu_pkg::word_t  divisor,
	output alu_pkg::dword_t quotient_remainder
);

	localparam int W = `ALU_WORD_WIDTH;

	// Operand magnitudes, most negative value maps to 2^(W-1)
	logic [W-1:0] divd_mag;
	logic [W-1:0] divs_mag;
	// Partial remainder, two extra bits for sign and doubling
	logic [W+1:0] rem;
	logic [W-1:0] quo;
	// Signed results before the special cases
	alu_pkg::word_t quo_signed;
	alu_pkg::word_t rem_signed;
	logic neg_quo;
	logic div_by_zero;
	logic overflow;

	assign divd_mag = dividend[W-1] ? -dividend : dividend;
	assign divs_mag = divisor[W-1] ? -divisor : divisor;

	// Unrolled non-restoring steps
	// Subtract when the partial remainder is non-negative, add when negative
	always_comb begin
		rem = '0;
		quo = divd_mag;
		for (int i = 0; i < W; i++) begin
			if (rem[W+1]) begin
				rem = {rem[W:0], quo[W-1]} + {2'b00, divs_mag};
			end else begin
				rem = {rem[W:0], quo[W-1]} - {2'b00, divs_mag};
			end
			// Quotient bit is set when the new remainder is non-negative
			quo = {quo[W-2:0], ~rem[W+1]};
		end
		// Final correction of a negative remainder
		if (rem[W+1]) begin
			rem = rem + {2'b00, divs_mag};
		end
	end

	// Truncation toward zero: quotient sign from both operands
	assign neg_quo = dividend[W-1] ^ divisor[W-1];
	assign quo_signed = neg_quo ? -quo : quo;
	// Remainder follows the dividend sign
	assign rem_signed = dividend[W-1] ? -rem[W-1:0] : rem[W-1:0];

	assign div_by_zero = (divisor == '0);
	assign overflow = (dividend == {1'b1, {(W-1){1'b0}}}) && (divisor == '1);

	always_comb begin
		if (div_by_zero) begin
			// All ones quotient, dividend passed through as remainder
			quotient_remainder.lo = '1;
			quotient_remainder.hi = dividend;
		end else if (overflow) begin
			// Most negative over -1 wraps to itself
			quotient_remainder.lo = dividend;
			quotient_remainder.hi = '0;
		end else begin
			quotient_remainder.lo = quo_signed;
			quotient_remainder.hi = rem_signed;
		end
	end

endmodule

/* source/alu.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module alu (
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::word_t   a,
	input  alu_pkg::word_t   b,
	output alu_pkg::dword_t  result
);

	localparam int W = `ALU_WORD_WIDTH;

	// Shift and rotate distance, low five bits of the bus
	logic [$clog2(W)-1:0] amt;

	alu_pkg::word_t and_res;
	alu_pkg::word_t or_res;
	alu_pkg::word_t neg_res;
	alu_pkg::word_t not_res;
	alu_pkg::word_t add_res;
	alu_pkg::word_t sub_res;
	alu_pkg::word_t shr_res;
	alu_pkg::word_t shra_res;
	alu_pkg::word_t shl_res;
	alu_pkg::word_t ror_res;
	alu_pkg::word_t rol_res;
	// Y doubled up so a plain shift becomes a rotate
	logic [2*W-1:0] ror_wide;
	logic [2*W-1:0] rol_wide;

	alu_pkg::dword_t mul_res;
	alu_pkg::dword_t div_res;

	assign amt = b[$clog2(W)-1:0];

	// Logic ops
	assign and_res = a & b;
	assign or_res  = a | b;
	// Unary ops on Y only
	assign neg_res = -a;
	assign not_res = ~a;

	// Add and subtract wrap modulo 2^W
	assign add_res = a + b;
	assign sub_res = a - b;

	assign shr_res  = a >> amt;
	// Arithmetic shift keeps the sign of Y
	assign shra_res = $signed(a) >>> amt;
	assign shl_res  = a << amt;

	assign ror_wide = {a, a} >> amt;
	assign rol_wide = {a, a} << amt;
	assign ror_res  = ror_wide[W-1:0];
	assign rol_res  = rol_wide[2*W-1:W];

	// Full-width signed multiply and divide
	booth_multiplier u_mul (
		.multiplicand (a),
		.multiplier   (b),
		.product      (mul_res)
	);

	nonrestoring_divider u_div (
		.dividend           (a),
		.divisor            (b),
		.quotient_remainder (div_res)
	);

	// Only mul and div fill the high half
	always_comb begin
		result = '0;
		case (op)
			alu_pkg::OP_AND:  result.lo = and_res;
			alu_pkg::OP_OR:   result.lo = or_res;
			alu_pkg::OP_NEG:  result.lo = neg_res;
			alu_pkg::OP_NOT:  result.lo = not_res;
			alu_pkg::OP_ADD:  result.lo = add_res;
			alu_pkg::OP_SUB:  result.lo = sub_res;
			alu_pkg::OP_MUL:  result = mul_res;
			alu_pkg::OP_DIV:  result = div_res;
			alu_pkg::OP_SHR:  result.lo = shr_res;
			alu_pkg::OP_SHRA: result.lo = shra_res;
			alu_pkg::OP_SHL:  result.lo = shl_res;
			alu_pkg::OP_ROR:  result.lo = ror_res;
			alu_pkg::OP_ROL:  result.lo = rol_res;
			// Spare codes leave the result at zero
			default:          result = '0;
		endcase
	end

endmodule

/* source/alu_datapath.sv */
`timescale 1ns/100ps

module alu_datapath (
	input  logic               clk,
	input  logic               rst_n,
	input  bus_pkg::bus_src_t  bus_sel,
	input  bus_pkg::reg_addr_t reg_addr,
	input  logic               reg_write,
	input  logic               y_load,
	input  logic               z_load,
	input  alu_pkg::alu_op_t   op,
	input  alu_pkg::word_t     in_data,
	output alu_pkg::word_t     bus_out,
	output alu_pkg::word_t     z_hi,
	output alu_pkg::word_t     z_lo
);

	// Internal bus and its sources
	alu_pkg::word_t bus;
	alu_pkg::word_t reg_rdata;
	// Operand latch, first ALU input
	alu_pkg::word_t y_reg;
	// Result register, both halves
	alu_pkg::dword_t z_reg;
	alu_pkg::dword_t alu_result;

	register_bank u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.write_en   (reg_write),
		.addr       (reg_addr),
		.write_data (bus),
		.read_data  (reg_rdata)
	);

	// Bus mux, no clock in the path
	always_comb begin
		case (bus_sel)
			bus_pkg::BUS_SRC_REG:  bus = reg_rdata;
			bus_pkg::BUS_SRC_IN:   bus = in_data;
			bus_pkg::BUS_SRC_Z_LO: bus = z_reg.lo;
			default:               bus = z_reg.hi;
		endcase
	end

	// Y from the bus, used from the next cycle on
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			y_reg <= '0;
		end else if (y_load) begin
			y_reg <= bus;
		end
	end

	// Y is operand a, the live bus is operand b
	alu u_alu (
		.op     (op),
		.a      (y_reg),
		.b      (bus),
		.result (alu_result)
	);

	// Z captures the result for the op in the load cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			z_reg <= '0;
		end else if (z_load) begin
			z_reg <= alu_result;
		end
	end

	assign bus_out = bus;
	assign z_hi = z_reg.hi;
	assign z_lo = z_reg.lo;

endmodule

/* verif/alu_datapath_assert.sv */
`timescale 1ns/100ps

module alu_datapath_assert (
	input logic             clk,
	input logic             rst_n,
	input logic             z_load,
	input alu_pkg::alu_op_t op,
	input alu_pkg::word_t   z_hi,
	input alu_pkg::word_t   z_lo
);

	// Reset edge clears both halves of Z
	a_reset_clears_z: assert property (
		@(posedge clk) !rst_n |=> (z_hi == '0) && (z_lo == '0)
	) else $error("Z not cleared after a reset edge");

	// No load strobe, no change in Z
	a_z_holds: assert property (
		@(posedge clk) rst_n && !z_load |=> $stable({z_hi, z_lo})
	) else $error("Z changed without z_load");

	// Single-word ops leave the high half empty
	// mul and div are the only ops that write it
	a_single_word_hi_zero: assert property (
		@(posedge clk)
		rst_n && z_load && (op != alu_pkg::OP_MUL) && (op != alu_pkg::OP_DIV)
		|=> z_hi == '0
	) else $error("z_hi nonzero after a single-word operation");

endmodule

/* verif/tb_alu_datapath.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module tb_alu_datapath;

	localparam int CLK_PERIOD = 100;
	// Random pairs per operation
	localparam int N_RAND = 24;
	// Reset, reads, writes, logic, shifts, mul/div, chaining, second reset, flush
	localparam int PLANNED_CYCLES = 5 + 18 + 32 + (12 * N_RAND + 6) + 322
		+ (4 * N_RAND + 100) + 12 + 25 + 2;
	localparam int WATCHDOG_NS = (PLANNED_CYCLES + 50) * CLK_PERIOD;

	logic clk;
	logic rst_n;
	bus_pkg::bus_src_t bus_sel;
	bus_pkg::reg_addr_t reg_addr;
	logic reg_write;
	logic y_load;
	logic z_load;
	alu_pkg::alu_op_t op;
	alu_pkg::word_t in_data;
	alu_pkg::word_t bus_out;
	alu_pkg::word_t z_hi;
	alu_pkg::word_t z_lo;

	integer seed = 32'h1bcc;
	// Model state as of the last edge
	alu_pkg::word_t shadow [`ALU_REG_COUNT];
	alu_pkg::word_t y_m;
	alu_pkg::dword_t z_m;
	// This cycle's effects land on the next edge
	logic pend_wr;
	logic pend_y;
	logic pend_z;
	bus_pkg::reg_addr_t pend_addr;
	alu_pkg::word_t pend_bus;
	alu_pkg::dword_t pend_res;
	// Expected Z values in load order
	alu_pkg::dword_t exp_q [$];
	alu_pkg::alu_op_t logic_ops [6] = '{alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_NEG,
		alu_pkg::OP_NOT, alu_pkg::OP_ADD, alu_pkg::OP_SUB};
	alu_pkg::alu_op_t shift_ops [5] = '{alu_pkg::OP_SHR, alu_pkg::OP_SHRA, alu_pkg::OP_SHL,
		alu_pkg::OP_ROR, alu_pkg::OP_ROL};
	// Zero, one, minus one, most negative, most positive
	alu_pkg::word_t corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

	alu_datapath dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus_sel   (bus_sel),
		.reg_addr  (reg_addr),
		.reg_write (reg_write),
		.y_load    (y_load),
		.z_load    (z_load),
		.op        (op),
		.in_data   (in_data),
		.bus_out   (bus_out),
		.z_hi      (z_hi),
		.z_lo      (z_lo)
	);

	bind alu_datapath alu_datapath_assert u_assert (
		.clk    (clk),
		.rst_n  (rst_n),
		.z_load (z_load),
		.op     (op),
		.z_hi   (z_hi),
		.z_lo   (z_lo)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog sized from the planned cycle count
	initial begin
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns", WATCHDOG_NS);
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

	function automatic alu_pkg::word_t rand_word();
		return $random(seed);
	endfunction

	// Expected result from the ALU rules with Y first and the bus second
	function automatic alu_pkg::dword_t ref_alu(input alu_pkg::alu_op_t f,
		input alu_pkg::word_t y, input alu_pkg::word_t b);
		alu_pkg::dword_t r;
		alu_pkg::word_t fill;
		int unsigned n;
		int sy;
		int sb;
		longint prod;
		r = '0;
		n = 32'(b[4:0]);
		sy = int'(y);
		sb = int'(b);
		// Sign bits shifted in from the top for shra
		fill = y[31] ? ~(32'hffff_ffff >> n) : 32'h0;
		case (f)
			alu_pkg::OP_AND:  r.lo = y & b;
			alu_pkg::OP_OR:   r.lo = y | b;
			alu_pkg::OP_NEG:  r.lo = ~y + 32'd1;
			alu_pkg::OP_NOT:  r.lo = ~y;
			alu_pkg::OP_ADD:  r.lo = y + b;
			alu_pkg::OP_SUB:  r.lo = y + ~b + 32'd1;
			alu_pkg::OP_MUL: begin
				prod = longint'(sy) * longint'(sb);
				r = prod;
			end
			alu_pkg::OP_DIV: begin
				if (b == 32'h0) begin
					r.lo = 32'hffff_ffff;
					r.hi = y;
				end else if (y == 32'h8000_0000 && b == 32'hffff_ffff) begin
					r.lo = y;
				end else begin
					// SV division truncates toward zero
					// Remainder keeps the dividend's sign
					r.lo = sy / sb;
					r.hi = sy % sb;
				end
			end
			alu_pkg::OP_SHR:  r.lo = y >> n;
			alu_pkg::OP_SHRA: r.lo = (y >> n) | fill;
			alu_pkg::OP_SHL:  r.lo = y << n;
			// Shift by 32 gives zero so amount 0 is a plain copy
			alu_pkg::OP_ROR:  r.lo = (y >> n) | (y << (32 - n));
			alu_pkg::OP_ROL:  r.lo = (y << n) | (y >> (32 - n));
			default:          r = '0;
		endcase
		return r;
	endfunction

	task automatic check_word(input string name, input alu_pkg::word_t want,
		input alu_pkg::word_t got);
		if (got !== want) begin
			$display("ERROR %s expected %h actual %h", name, want, got);
			$display("Test FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_dword(input string name, input alu_pkg::dword_t want,
		input alu_pkg::dword_t got);
		if (got !== want) begin
			$display("ERROR %s expected %h actual %h", name, want, got);
			$display("Test FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// One bus cycle with bus_out checked mid-cycle
	task automatic step(input bus_pkg::bus_src_t sel, input bus_pkg::reg_addr_t addr,
		input logic wr, input logic yl, input logic zl, input alu_pkg::alu_op_t f,
		input alu_pkg::word_t data);
		alu_pkg::word_t bus_m;
		@(posedge clk);
		// Last cycle's strobes take effect on this edge
		if (pend_wr) shadow[pend_addr] = pend_bus;
		if (pend_y) y_m = pend_bus;
		if (pend_z) z_m = pend_res;
		bus_sel <= sel;
		reg_addr <= addr;
		reg_write <= wr;
		y_load <= yl;
		z_load <= zl;
		op <= f;
		in_data <= data;
		case (sel)
			bus_pkg::BUS_SRC_REG:  bus_m = shadow[addr];
			bus_pkg::BUS_SRC_IN:   bus_m = data;
			bus_pkg::BUS_SRC_Z_LO: bus_m = z_m.lo;
			default:               bus_m = z_m.hi;
		endcase
		pend_wr = wr;
		pend_y = yl;
		pend_z = zl;
		pend_addr = addr;
		pend_bus = bus_m;
		pend_res = ref_alu(f, y_m, bus_m);
		if (zl) exp_q.push_back(pend_res);
		@(negedge clk);
		check_word("bus_out", bus_m, bus_out);
	endtask

	// Y from in_data and then the op with b on the bus
	task automatic run_op(input alu_pkg::alu_op_t f, input alu_pkg::word_t a,
		input alu_pkg::word_t b);
		step(bus_pkg::BUS_SRC_IN, 4'd0, 1'b0, 1'b1, 1'b0, alu_pkg::OP_AND, a);
		step(bus_pkg::BUS_SRC_IN, 4'd0, 1'b0, 1'b0, 1'b1, f, b);
	endtask

	// Mid-run reset clears the model along with the DUT
	task automatic hold_reset(input int cycles);
		@(posedge clk);
		rst_n <= 1'b0;
		reg_write <= 1'b0;
		y_load <= 1'b0;
		z_load <= 1'b0;
		repeat (cycles) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < `ALU_REG_COUNT; i++) begin
			shadow[i] = '0;
		end
		y_m = '0;
		z_m = '0;
		pend_wr = 1'b0;
		pend_y = 1'b0;
		pend_z = 1'b0;
	endtask

	// Compare Z one edge after each load
	initial begin
		logic load_seen;
		alu_pkg::dword_t want;
		forever begin
			@(posedge clk);
			load_seen = z_load;
			@(negedge clk);
			if (load_seen) begin
				if (exp_q.size() == 0) begin
					$display("Z was loaded with no expected result waiting");
					$display("Test FAILED");
					$fatal(1, "unexpected Z load");
				end else begin
					want = exp_q.pop_front();
					check_word("z_lo", want.lo, z_lo);
					check_word("z_hi", want.hi, z_hi);
					check_dword("z", want, {z_hi, z_lo});
				end
			end
		end
	end

	initial begin
		alu_pkg::word_t a;
		alu_pkg::word_t b;
		rst_n = 1'b0;
		bus_sel = bus_pkg::BUS_SRC_IN;
		reg_addr = '0;
		reg_write = 1'b0;
		y_load = 1'b0;
		z_load = 1'b0;
		op = alu_pkg::OP_AND;
		in_data = '0;
		y_m = '0;
		z_m = '0;
		pend_wr = 1'b0;
		pend_y = 1'b0;
		pend_z = 1'b0;
		for (int i = 0; i < `ALU_REG_COUNT; i++) begin
			shadow[i] = '0;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// Every register and both Z halves read zero after reset
		for (int i = 0; i < `ALU_REG_COUNT; i++) begin
			step(bus_pkg::BUS_SRC_REG, bus_pkg::reg_addr_t'(i), 1'b0, 1'b0, 1'b0,
				alu_pkg::OP_AND, '0);
		end
		step(bus_pkg::BUS_SRC_Z_LO, 4'd0, 1'b0, 1'b0, 1'b0, alu_pkg::OP_AND, '0);
		step(bus_pkg::BUS_SRC_Z_HI, 4'd0, 1'b0, 1'b0, 1'b0, alu_pkg::OP_AND, '0);

		// Fill the bank from in_data and read it all back
		for (int i = 0; i < `ALU_REG_COUNT; i++) begin
			step(bus_pkg::BUS_SRC_IN, bus_pkg::reg_addr_t'(i), 1'b1, 1'b0, 1'b0,
				alu_pkg::OP_AND, rand_word());
		end
		for (int i = 0; i < `ALU_REG_COUNT; i++) begin
			step(bus_pkg::BUS_SRC_REG, bus_pkg::reg_addr_t'(i), 1'b0, 1'b0, 1'b0,
				alu_pkg::OP_AND, '0);
		end

		// Logic and add/sub with wrap cases and a spare code
		foreach (logic_ops[k]) begin
			for (int i = 0; i < N_RAND; i++) begin
				run_op(logic_ops[k], rand_word(), rand_word());
			end
		end
		run_op(alu_pkg::OP_ADD, 32'hffff_ffff, 32'h1);
		run_op(alu_pkg::OP_SUB, 32'h0, 32'h1);
		run_op(alu_pkg::alu_op_t'(4'd13), rand_word(), rand_word());

		// Every shift amount for each shift and rotate
		foreach (shift_ops[k]) begin
			for (int amt = 0; amt < 32; amt++) begin
				a = rand_word();
				b = rand_word();
				b[4:0] = 5'(amt);
				run_op(shift_ops[k], a, b);
			end
		end
		run_op(alu_pkg::OP_SHRA, 32'h8000_0000, 32'd31);

		// Random signed pairs with small divisors on odd passes
		for (int i = 0; i < N_RAND; i++) begin
			run_op(alu_pkg::OP_MUL, rand_word(), rand_word());
			a = rand_word();
			b = rand_word();
			if (i % 2 == 1) b = alu_pkg::word_t'($signed(b) >>> 20);
			run_op(alu_pkg::OP_DIV, a, b);
		end
		// Corner pairs cover divide by zero and the overflow case
		foreach (corners[i]) begin
			foreach (corners[j]) begin
				run_op(alu_pkg::OP_MUL, corners[i], corners[j]);
				run_op(alu_pkg::OP_DIV, corners[i], corners[j]);
			end
		end

		// Write-back of both Z halves and Z feeding later ops
		run_op(alu_pkg::OP_MUL, rand_word(), rand_word());
		step(bus_pkg::BUS_SRC_Z_LO, 4'd3, 1'b1, 1'b0, 1'b0, alu_pkg::OP_AND, '0);
		step(bus_pkg::BUS_SRC_Z_HI, 4'd4, 1'b1, 1'b0, 1'b0, alu_pkg::OP_AND, '0);
		step(bus_pkg::BUS_SRC_REG, 4'd3, 1'b0, 1'b0, 1'b0, alu_pkg::OP_AND, '0);
		step(bus_pkg::BUS_SRC_REG, 4'd4, 1'b0, 1'b0, 1'b0, alu_pkg::OP_AND, '0);
		step(bus_pkg::BUS_SRC_Z_LO, 4'd0, 1'b0, 1'b1, 1'b0, alu_pkg::OP_AND, '0);
		step(bus_pkg::BUS_SRC_REG, 4'd4, 1'b0, 1'b0, 1'b1, alu_pkg::OP_ADD, '0);
		run_op(alu_pkg::OP_DIV, rand_word(), 32'd1000);
		step(bus_pkg::BUS_SRC_Z_HI, 4'd0, 1'b0, 1'b1, 1'b0, alu_pkg::OP_AND, '0);
		step(bus_pkg::BUS_SRC_Z_LO, 4'd0, 1'b0, 1'b0, 1'b1, alu_pkg::OP_MUL, '0);

		// Reset again with the bank, Y and Z holding data
		hold_reset(5);
		for (int i = 0; i < `ALU_REG_COUNT; i++) begin
			step(bus_pkg::BUS_SRC_REG, bus_pkg::reg_addr_t'(i), 1'b0, 1'b0, 1'b0,
				alu_pkg::OP_AND, '0);
		end
		step(bus_pkg::BUS_SRC_Z_LO, 4'd0, 1'b0, 1'b0, 1'b0, alu_pkg::OP_AND, '0);
		step(bus_pkg::BUS_SRC_Z_HI, 4'd0, 1'b0, 1'b0, 1'b0, alu_pkg::OP_AND, '0);
		// Y OR zero shows whether Y was cleared
		step(bus_pkg::BUS_SRC_IN, 4'd0, 1'b0, 1'b0, 1'b1, alu_pkg::OP_OR, '0);

		// Idle cycles let the last load reach the compare process
		step(bus_pkg::BUS_SRC_IN, 4'd0, 1'b0, 1'b0, 1'b0, alu_pkg::OP_AND, '0);
		step(bus_pkg::BUS_SRC_IN, 4'd0, 1'b0, 1'b0, 1'b0, alu_pkg::OP_AND, '0);

		if (exp_q.size() != 0) begin
			$display("%0d expected results were never compared", exp_q.size());
			$display("Test FAILED");
			$fatal(1, "results left unchecked");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

/* project.f */
+incdir+source
source/alu_pkg.sv
source/bus_pkg.sv
source/register_bank.sv
source/booth_multiplier.sv
source/nonrestoring_divider.sv
source/alu.sv
source/alu_datapath.sv
verif/alu_datapath_assert.sv
verif/tb_alu_datapath.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ALU datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_alu_datapath -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
	exit 0
fi
echo "Pass message missing from simulation output"
exit 1
